/* verilog/opc_sys_defs.svh */
`ifndef OPC_SYS_DEFS_SVH
`define OPC_SYS_DEFS_SVH

// ---------------------------------------------------------------------------
// Bus and memory sizes
// ---------------------------------------------------------------------------

`define OPC_DSIZE 32
`define OPC_ASIZE 20

// 1024 words of block RAM
`define OPC_RAMSIZE 10

// Short bit time keeps UART frames quick in simulation
`define OPC_CLKS_PER_BIT 16

// ---------------------------------------------------------------------------
// I/O register offsets, decoded from the low address bits
// ---------------------------------------------------------------------------

`define OPC_IO_UART_STAT 2'd0
`define OPC_IO_UART_DATA 2'd1
`define OPC_IO_DISP_CFG 2'd2

`endif

/* verilog/opc_sys_pkg.sv */
`include "opc_sys_defs.svh"

package opc_sys_pkg;

   // Bus payloads
   typedef logic [`OPC_DSIZE-1:0] word_t;
   typedef logic [`OPC_ASIZE-1:0] addr_t;

   // One UART character
   typedef logic [7:0] byte_t;

   // Hex digit, also used for the brightness duty
   typedef logic [3:0] nibble_t;

   // Display configuration register
   typedef struct packed {
      nibble_t duty;
      logic    src;
   } disp_cfg_t;

   // Target of an I/O space access
   typedef enum logic [1:0] {
      io_uart_stat,
      io_uart_data,
      io_disp_cfg,
      io_none
   } io_sel_t;

endpackage

/* verilog/word_ram.sv */
`include "opc_sys_defs.svh"

module word_ram import opc_sys_pkg::*; (
   input  logic                    cpu_clk,
   input  logic                    en,
   input  logic                    we,
   input  logic [`OPC_RAMSIZE-1:0] addr,
   input  word_t                   wdata,
   output word_t                   rdata
);

   localparam int DEPTH = 1 << `OPC_RAMSIZE;

   word_t mem [0:DEPTH-1];

   // Single port, read data registered
   always_ff @(posedge cpu_clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
            // Write-first: new word shows on the read port
            rdata     <= wdata;
         end else begin
            rdata <= mem[addr];
         end
      end
   end

endmodule

/* verilog/uart.sv */
`include "opc_sys_defs.svh"

module uart import opc_sys_pkg::*; (
   input  logic  cpu_clk,
   input  logic  rst,
   input  logic  wr,
   input  logic  rd,
   input  logic  sel_data,
   input  byte_t wdata,
   output word_t rdata,
   output logic  tx_ready,
   input  logic  rxd,
   output logic  txd
);

   localparam int CPB = `OPC_CLKS_PER_BIT;
   localparam int CW  = $clog2(CPB);

   // Transmitter
   logic [9:0]    tx_shift;
   logic [3:0]    tx_bits;
   logic [CW-1:0] tx_cnt;
   logic          tx_busy;
   logic          tx_tick;

   // Receiver
   logic          rx_meta;
   logic          rx_sync;
   logic          rx_busy;
   logic [CW-1:0] rx_cnt;
   logic [3:0]    rx_bits;
   logic          rx_tick;
   byte_t         rx_shift;
   byte_t         rx_byte;
   logic          rx_valid;
   logic          rx_overrun;

   // ------------------------------------------------------------------------
   // Transmit: start bit, 8 data bits LSB first, stop bit
   // ------------------------------------------------------------------------

   assign tx_tick = (tx_cnt == CW'(CPB - 1));

   always_ff @(posedge cpu_clk) begin
      if (rst) begin
         tx_shift <= '1;
         tx_bits  <= '0;
         tx_cnt   <= '0;
         tx_busy  <= 1'b0;
      end else if (wr && sel_data && !tx_busy) begin
         tx_shift <= {1'b1, wdata, 1'b0};
         tx_bits  <= '0;
         tx_cnt   <= '0;
         tx_busy  <= 1'b1;
      end else if (tx_busy) begin
         if (tx_tick) begin
            tx_cnt   <= '0;
            // Ones shift in behind, so the line idles high
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bits == 4'd9)
               tx_busy <= 1'b0;
            else
               tx_bits <= tx_bits + 4'd1;
         end else begin
            tx_cnt <= tx_cnt + 1'b1;
         end
      end
   end

   assign txd      = tx_shift[0];
   assign tx_ready = !tx_busy;

   // ------------------------------------------------------------------------
   // Receive with mid-bit sampling
   // ------------------------------------------------------------------------

   assign rx_tick = (rx_cnt == CW'(CPB - 1));

   always_ff @(posedge cpu_clk) begin
      if (rst) begin
         rx_meta    <= 1'b1;
         rx_sync    <= 1'b1;
         rx_busy    <= 1'b0;
         rx_cnt     <= '0;
         rx_bits    <= '0;
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end else begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
         if (rd && sel_data) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
         end
         if (!rx_busy) begin
            // Falling edge: first tick lands half a bit later
            if (!rx_sync) begin
               rx_busy <= 1'b1;
               rx_cnt  <= CW'(CPB / 2);
               rx_bits <= '0;
            end
         end else if (rx_tick) begin
            rx_cnt  <= '0;
            rx_bits <= rx_bits + 4'd1;
            if (rx_bits == 4'd0) begin
               // Glitch, not a real start bit
               if (rx_sync)
                  rx_busy <= 1'b0;
            end else if (rx_bits == 4'd9) begin
               rx_busy  <= 1'b0;
               rx_valid <= 1'b1;
               if (rx_valid && !(rd && sel_data))
                  rx_overrun <= 1'b1;
            end
         end else begin
            rx_cnt <= rx_cnt + 1'b1;
         end
      end
   end

   // Data path of the receiver
   always_ff @(posedge cpu_clk) begin
      if (rx_busy && rx_tick) begin
         if (rx_bits >= 4'd1 && rx_bits <= 4'd8)
            rx_shift <= {rx_sync, rx_shift[7:1]};
         else if (rx_bits == 4'd9)
            rx_byte <= rx_shift;
      end
   end

   // Status: bit 0 rx_valid, bit 1 tx_busy, bit 2 overrun
   assign rdata = sel_data ? {{(`OPC_DSIZE-8){1'b0}}, rx_byte}
                           : {{(`OPC_DSIZE-3){1'b0}}, rx_overrun, tx_busy, rx_valid};

endmodule

/* verilog/display_regs.sv */
`include "opc_sys_defs.svh"

module display_regs import opc_sys_pkg::*; (
   input  logic        cpu_clk,
   input  logic        rst,
   input  logic        cfg_wr,
   input  word_t       cfg_wdata,
   output word_t       cfg_rdata,
   input  logic        last_valid,
   input  addr_t       last_addr,
   input  word_t       last_rdata,
   output logic [15:0] disp_value,
   output nibble_t     disp_duty
);

   disp_cfg_t cfg;

   // Bit 0 selects the source, bits 7:4 set the duty
   always_ff @(posedge cpu_clk) begin
      if (rst) begin
         cfg <= '0;
      end else if (cfg_wr) begin
         cfg.src  <= cfg_wdata[0];
         cfg.duty <= cfg_wdata[7:4];
      end
   end

   // Capture what the display shows at the end of every access
   always_ff @(posedge cpu_clk) begin
      if (rst)
         disp_value <= '0;
      else if (last_valid)
         disp_value <= cfg.src ? last_rdata[15:0] : last_addr[15:0];
   end

   assign cfg_rdata = {{(`OPC_DSIZE-8){1'b0}}, cfg.duty, 3'b000, cfg.src};
   assign disp_duty = cfg.duty;

endmodule

/* verilog/sevenseg_scan.sv */
module sevenseg_scan import opc_sys_pkg::*; (
   input  logic        cpu_clk,
   input  logic        rst,
   input  logic [15:0] value,
   input  nibble_t     duty,
   output logic [6:0]  seg,
   output logic [3:0]  an
);

   logic [5:0] scan_cnt;
   logic [1:0] digit;
   nibble_t    phase;
   nibble_t    nibble;
   logic       lit;

   // Segments gfedcba, driven low to light
   function automatic logic [6:0] hex_to_seg(input nibble_t hex);
      logic [6:0] on;
      case (hex)
         4'h0: on = 7'h3f;
         4'h1: on = 7'h06;
         4'h2: on = 7'h5b;
         4'h3: on = 7'h4f;
         4'h4: on = 7'h66;
         4'h5: on = 7'h6d;
         4'h6: on = 7'h7d;
         4'h7: on = 7'h07;
         4'h8: on = 7'h7f;
         4'h9: on = 7'h6f;
         4'ha: on = 7'h77;
         4'hb: on = 7'h7c;
         4'hc: on = 7'h39;
         4'hd: on = 7'h5e;
         4'he: on = 7'h79;
         default: on = 7'h71;
      endcase
      return ~on;
   endfunction

   // 16 cycles per digit
   assign digit = scan_cnt[5:4];
   assign phase = scan_cnt[3:0];

   // Digit 3 is leftmost and shows the top nibble
   always_comb begin
      case (digit)
         2'd0:    nibble = value[3:0];
         2'd1:    nibble = value[7:4];
         2'd2:    nibble = value[11:8];
         default: nibble = value[15:12];
      endcase
   end

   // Lit for the first 16 - duty cycles of the slot
   assign lit = ({1'b0, phase} + {1'b0, duty}) < 5'd16;

   always_ff @(posedge cpu_clk) begin
      if (rst) begin
         scan_cnt <= '0;
         seg      <= '1;
         an       <= '1;
      end else begin
         scan_cnt <= scan_cnt + 6'd1;
         seg      <= hex_to_seg(nibble);
         an       <= lit ? ~(4'b0001 << digit) : 4'b1111;
      end
   end

endmodule

/* verilog/bus_bridge.sv */
`include "opc_sys_defs.svh"

module bus_bridge import opc_sys_pkg::*; (
   input  logic                    cpu_clk,
   input  logic                    rst,
   input  logic                    req,
   input  logic                    rnw,
   input  logic                    vda,
   input  logic                    vio,
   input  addr_t                   addr,
   input  word_t                   wdata,
   output logic                    ack,
   output word_t                   rdata,
   output logic                    ram_en,
   output logic                    ram_we,
   output logic [`OPC_RAMSIZE-1:0] ram_addr,
   output word_t                   ram_wdata,
   input  word_t                   ram_rdata,
   output logic                    uart_wr,
   output logic                    uart_rd,
   output logic                    uart_sel_data,
   output byte_t                   uart_wdata,
   input  word_t                   uart_rdata,
   input  logic                    tx_ready,
   output logic                    cfg_wr,
   output word_t                   cfg_wdata,
   input  word_t                   cfg_rdata,
   output logic                    last_valid,
   output addr_t                   last_addr,
   output word_t                   last_rdata
);

   typedef enum logic [1:0] {st_idle, st_access, st_wait_ram, st_done} state_t;

   state_t  state;
   io_sel_t io_sel;
   io_sel_t io_sel_q;
   logic    is_mem_q;
   logic    is_io_q;
   logic    rnw_q;
   addr_t   addr_q;
   word_t   wdata_q;
   word_t   io_rdata;
   logic    uart_target;
   logic    uart_hold;

   // I/O target from the low address bits
   always_comb begin
      case (addr[1:0])
         `OPC_IO_UART_STAT: io_sel = io_uart_stat;
         `OPC_IO_UART_DATA: io_sel = io_uart_data;
         `OPC_IO_DISP_CFG:  io_sel = io_disp_cfg;
         default:           io_sel = io_none;
      endcase
   end

   assign uart_target = is_io_q && (io_sel_q == io_uart_stat || io_sel_q == io_uart_data);

   // Only back-pressure: data write while the transmitter is still busy
   assign uart_hold = is_io_q && io_sel_q == io_uart_data && !rnw_q && !tx_ready;

   // ------------------------------------------------------------------------
   // Four-phase sequencer
   // ------------------------------------------------------------------------

   always_ff @(posedge cpu_clk) begin
      if (rst) begin
         state      <= st_idle;
         last_valid <= 1'b0;
      end else begin
         last_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (req)
                  state <= st_access;
            end
            st_access: begin
               if (is_mem_q) begin
                  state <= st_wait_ram;
               end else if (!uart_hold) begin
                  state      <= st_done;
                  last_valid <= 1'b1;
               end
            end
            st_wait_ram: begin
               state      <= st_done;
               last_valid <= 1'b1;
            end
            default: begin
               // Hold ack until the master lets go of req
               if (!req)
                  state <= st_idle;
            end
         endcase
      end
   end

   // Latch the request; memory space wins over I/O space
   always_ff @(posedge cpu_clk) begin
      if (state == st_idle && req) begin
         is_mem_q <= vda;
         is_io_q  <= vio && !vda;
         io_sel_q <= io_sel;
         rnw_q    <= rnw;
         addr_q   <= addr;
         wdata_q  <= wdata;
      end
   end

   // Read data mux for the I/O targets, zero when nothing is selected
   always_comb begin
      io_rdata = '0;
      if (is_io_q && rnw_q) begin
         if (uart_target)
            io_rdata = uart_rdata;
         else if (io_sel_q == io_disp_cfg)
            io_rdata = cfg_rdata;
      end
   end

   always_ff @(posedge cpu_clk) begin
      if (state == st_wait_ram)
         rdata <= rnw_q ? ram_rdata : '0;
      else if (state == st_access && !is_mem_q && !uart_hold)
         rdata <= io_rdata;
   end

   assign ack = (state == st_done);

   // RAM strobes
   assign ram_en    = (state == st_access) && is_mem_q;
   assign ram_we    = !rnw_q;
   assign ram_addr  = addr_q[`OPC_RAMSIZE-1:0];
   assign ram_wdata = wdata_q;

   // UART strobes
   assign uart_wr       = (state == st_access) && uart_target && !rnw_q && !uart_hold;
   assign uart_rd       = (state == st_access) && uart_target && rnw_q;
   assign uart_sel_data = (io_sel_q == io_uart_data);
   assign uart_wdata    = wdata_q[7:0];

   // Display configuration
   assign cfg_wr    = (state == st_access) && is_io_q && !rnw_q && io_sel_q == io_disp_cfg;
   assign cfg_wdata = wdata_q;

   // Values seen by the display on each completed access
   assign last_addr  = addr_q;
   assign last_rdata = rdata;

endmodule

/* verilog/opc_system.sv */
`include "opc_sys_defs.svh"

module opc_system import opc_sys_pkg::*; (
   input  logic       cpu_clk,
   input  logic       rst,
   input  logic       req,
   input  logic       rnw,
   input  logic       vda,
   input  logic       vio,
   input  addr_t      addr,
   input  word_t      wdata,
   output logic       ack,
   output word_t      rdata,
   input  logic       rxd,
   output logic       txd,
   output logic [6:0] seg,
   output logic [3:0] an
);

   // RAM side
   logic                    ram_en;
   logic                    ram_we;
   logic [`OPC_RAMSIZE-1:0] ram_addr;
   word_t                   ram_wdata;
   word_t                   ram_rdata;

   // UART side
   logic                    uart_wr;
   logic                    uart_rd;
   logic                    uart_sel_data;
   byte_t                   uart_wdata;
   word_t                   uart_rdata;
   logic                    tx_ready;

   // Display configuration and scanner
   logic                    cfg_wr;
   word_t                   cfg_wdata;
   word_t                   cfg_rdata;
   logic                    last_valid;
   addr_t                   last_addr;
   word_t                   last_rdata;
   logic [15:0]             disp_value;
   nibble_t                 disp_duty;

   bus_bridge u_bus_bridge (
      .cpu_clk       (cpu_clk),
      .rst           (rst),
      .req           (req),
      .rnw           (rnw),
      .vda           (vda),
      .vio           (vio),
      .addr          (addr),
      .wdata         (wdata),
      .ack           (ack),
      .rdata         (rdata),
      .ram_en        (ram_en),
      .ram_we        (ram_we),
      .ram_addr      (ram_addr),
      .ram_wdata     (ram_wdata),
      .ram_rdata     (ram_rdata),
      .uart_wr       (uart_wr),
      .uart_rd       (uart_rd),
      .uart_sel_data (uart_sel_data),
      .uart_wdata    (uart_wdata),
      .uart_rdata    (uart_rdata),
      .tx_ready      (tx_ready),
      .cfg_wr        (cfg_wr),
      .cfg_wdata     (cfg_wdata),
      .cfg_rdata     (cfg_rdata),
      .last_valid    (last_valid),
      .last_addr     (last_addr),
      .last_rdata    (last_rdata)
   );

   word_ram u_word_ram (
      .cpu_clk (cpu_clk),
      .en      (ram_en),
      .we      (ram_we),
      .addr    (ram_addr),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   uart u_uart (
      .cpu_clk  (cpu_clk),
      .rst      (rst),
      .wr       (uart_wr),
      .rd       (uart_rd),
      .sel_data (uart_sel_data),
      .wdata    (uart_wdata),
      .rdata    (uart_rdata),
      .tx_ready (tx_ready),
      .rxd      (rxd),
      .txd      (txd)
   );

   display_regs u_display_regs (
      .cpu_clk    (cpu_clk),
      .rst        (rst),
      .cfg_wr     (cfg_wr),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .last_valid (last_valid),
      .last_addr  (last_addr),
      .last_rdata (last_rdata),
      .disp_value (disp_value),
      .disp_duty  (disp_duty)
   );

   sevenseg_scan u_sevenseg_scan (
      .cpu_clk (cpu_clk),
      .rst     (rst),
      .value   (disp_value),
      .duty    (disp_duty),
      .seg     (seg),
      .an      (an)
   );

endmodule

/* verification/opc_system_assertions.sv */
module opc_system_assertions (
   input logic cpu_clk,
   input logic rst,
   input logic req,
   input logic ack,
   input logic ram_en,
   input logic uart_wr,
   input logic uart_rd,
   input logic cfg_wr
);

   timeunit 1ns;
   timeprecision 1ps;

   int failures = 0;

   // ack only answers a pending request
   ack_needs_req: assert property (@(posedge cpu_clk) disable iff (rst) $rose(ack) |-> req)
      else begin
         failures++;
         $error("ack rose while req was low");
      end

   // Completed access stays acknowledged while the master holds req
   ack_held: assert property (@(posedge cpu_clk) disable iff (rst) (ack && req) |=> ack)
      else begin
         failures++;
         $error("ack dropped before req fell");
      end

   // Memory and I/O strobes never overlap
   one_target: assert property (@(posedge cpu_clk) disable iff (rst)
                                !(ram_en && (uart_wr || uart_rd || cfg_wr)))
      else begin
         failures++;
         $error("RAM and I/O strobes active in the same cycle");
      end

endmodule

bind bus_bridge opc_system_assertions u_opc_system_assertions (
   .cpu_clk (cpu_clk),
   .rst     (rst),
   .req     (req),
   .ack     (ack),
   .ram_en  (ram_en),
   .uart_wr (uart_wr),
   .uart_rd (uart_rd),
   .cfg_wr  (cfg_wr)
);

/* verification/tb_opc_system.sv */
`include "opc_sys_defs.svh"

module tb_opc_system import opc_sys_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int LFSR_WORDS  = 16;
   localparam int EXTRA_XFERS = 16;
   localparam int UART_FRAMES = 3;

   // Lit segments per hex digit
   // Bit n is set when digit n lights the segment
   localparam logic [15:0] SEG_A = 16'hd7ed;
   localparam logic [15:0] SEG_B = 16'h279f;
   localparam logic [15:0] SEG_C = 16'h2ffb;
   localparam logic [15:0] SEG_D = 16'h7b6d;
   localparam logic [15:0] SEG_E = 16'hfd45;
   localparam logic [15:0] SEG_F = 16'hdf71;
   localparam logic [15:0] SEG_G = 16'hef7c;

   logic       cpu_clk;
   logic       rst;
   logic       req;
   logic       rnw;
   logic       vda;
   logic       vio;
   addr_t      addr;
   word_t      wdata;
   logic       ack;
   word_t      rdata;
   logic       serial;
   logic [6:0] seg;
   logic [3:0] an;

   // Stimulus lines from the data file
   byte        op_q [$];
   byte        sp_q [$];
   addr_t      addr_q [$];
   word_t      data_q [$];
   word_t      exp_q [$];

   word_t      lfsr_exp [LFSR_WORDS];
   logic [31:0] lfsr_state;
   int         pass_count = 0;
   int         fail_count = 0;
   int         cycle_count = 0;
   int         cycle_limit = 0;
   logic       loaded;

   // txd loops straight back into rxd
   opc_system u_opc_system (
      .cpu_clk (cpu_clk),
      .rst     (rst),
      .req     (req),
      .rnw     (rnw),
      .vda     (vda),
      .vio     (vio),
      .addr    (addr),
      .wdata   (wdata),
      .ack     (ack),
      .rdata   (rdata),
      .rxd     (serial),
      .txd     (serial),
      .seg     (seg),
      .an      (an)
   );

   initial begin
      cpu_clk = 1'b0;
      forever #50 cpu_clk = ~cpu_clk;
   end

   initial begin
      wait (cycle_limit != 0);
      while (cycle_count < cycle_limit) begin
         @(posedge cpu_clk);
         cycle_count++;
      end
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Checks and helpers
   // ------------------------------------------------------------------------

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      assert (actual === expected) begin
         pass_count++;
      end else begin
         $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
         fail_count++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond === 1'b1) begin
         pass_count++;
      end else begin
         $display("ERROR at %0t: %s", $time, what);
         fail_count++;
      end
   endtask

   task automatic report_test(input string name, input int fails_before, input int checks_before);
      $display("%-18s %0d checks, %0d errors", name,
               pass_count + fail_count - checks_before, fail_count - fails_before);
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic word_t random_word();
      word_t w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
      return w;
   endfunction

   // Active-low gfedcba from the per-segment tables
   function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
      logic [6:0] lit;
      lit = {SEG_G[hex], SEG_F[hex], SEG_E[hex], SEG_D[hex], SEG_C[hex], SEG_B[hex], SEG_A[hex]};
      return ~lit;
   endfunction

   // Four-phase bus master
   // lat counts rising edges from req to ack
   task automatic bus_xfer(input logic op_rnw, input logic mem, input logic io, input addr_t a,
                           input word_t d, output word_t q, output int lat);
      logic ack_seen;
      @(posedge cpu_clk);
      req   <= 1'b1;
      rnw   <= op_rnw;
      vda   <= mem;
      vio   <= io;
      addr  <= a;
      wdata <= d;
      lat = 0;
      ack_seen = 1'b0;
      while (!ack_seen) begin
         @(posedge cpu_clk);
         lat++;
         @(negedge cpu_clk);
         ack_seen = ack;
      end
      q = rdata;
      @(posedge cpu_clk);
      req <= 1'b0;
      @(negedge cpu_clk);
      while (ack)
         @(negedge cpu_clk);
   endtask

   task automatic load_stimulus(output logic ok);
      int    fd;
      int    n;
      string line;
      byte   op_c;
      byte   sp_c;
      addr_t a;
      word_t d;
      word_t e;
      fd = $fopen("verification/opc_system_stimulus.txt", "r");
      ok = (fd != 0);
      if (!ok) begin
         $display("ERROR: cannot open verification/opc_system_stimulus.txt");
         fail_count++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %c %h %h %h", op_c, sp_c, a, d, e);
               if (n == 5) begin
                  op_q.push_back(op_c);
                  sp_q.push_back(sp_c);
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  exp_q.push_back(e);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------

   task automatic reset_test();
      int fb;
      int cb;
      fb = fail_count;
      cb = pass_count + fail_count;
      @(negedge cpu_clk);
      check_value("ack", 32'h0, ack);
      check_value("txd", 32'h1, serial);
      check_value("an", 32'hf, an);
      report_test("reset", fb, cb);
   endtask

   task automatic file_test();
      word_t q;
      int    lat;
      int    fb;
      int    cb;
      fb = fail_count;
      cb = pass_count + fail_count;
      foreach (op_q[i]) begin
         bus_xfer(op_q[i] == "R", sp_q[i] == "M", sp_q[i] == "I", addr_q[i], data_q[i], q, lat);
         check_value("ack latency", (sp_q[i] == "M") ? 3 : 2, lat);
         if (op_q[i] == "R")
            check_value($sformatf("rdata @%h", addr_q[i]), exp_q[i], q);
      end
      report_test("file transactions", fb, cb);
   endtask

   task automatic lfsr_test();
      word_t q;
      int    lat;
      int    fb;
      int    cb;
      fb = fail_count;
      cb = pass_count + fail_count;
      for (int i = 0; i < LFSR_WORDS; i++) begin
         lfsr_exp[i] = random_word();
         bus_xfer(1'b0, 1'b1, 1'b0, addr_t'(20'h00100 + i), lfsr_exp[i], q, lat);
      end
      for (int i = 0; i < LFSR_WORDS; i++) begin
         bus_xfer(1'b1, 1'b1, 1'b0, addr_t'(20'h00100 + i), '0, q, lat);
         check_value($sformatf("rdata @%h", 20'h00100 + i), lfsr_exp[i], q);
      end
      report_test("lfsr ram burst", fb, cb);
   endtask

   // Read status until one of the mask bits is set
   task automatic poll_status(input word_t mask, output logic found);
      word_t q;
      int    lat;
      int    polls;
      found = 1'b0;
      polls = 0;
      while (!found && polls < 100) begin
         bus_xfer(1'b1, 1'b0, 1'b1, 20'h0, '0, q, lat);
         found = (q & mask) != 0;
         polls++;
      end
   endtask

   task automatic uart_test();
      word_t q;
      int    lat;
      int    fb;
      int    cb;
      logic  found;
      fb = fail_count;
      cb = pass_count + fail_count;
      bus_xfer(1'b0, 1'b0, 1'b1, 20'h1, 32'h5a, q, lat);
      check_value("ack latency", 2, lat);
      poll_status(32'h1, found);
      expect_true(found, "looped back byte never set rx_valid");
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h0, '0, q, lat);
      check_value("uart status", 32'h1, q & 32'h5);
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h1, '0, q, lat);
      check_value("uart rx data", 32'h5a, q);
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h0, '0, q, lat);
      check_value("uart status", 32'h0, q & 32'h1);
      // Second write has to wait for the first frame
      bus_xfer(1'b0, 1'b0, 1'b1, 20'h1, 32'h3c, q, lat);
      check_value("ack latency", 2, lat);
      bus_xfer(1'b0, 1'b0, 1'b1, 20'h1, 32'hc3, q, lat);
      expect_true(lat > 2, "second UART write was acknowledged without waiting");
      poll_status(32'h4, found);
      expect_true(found, "two unread bytes did not raise overrun");
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h1, '0, q, lat);
      check_value("uart rx data", 32'hc3, q);
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h0, '0, q, lat);
      check_value("uart status", 32'h0, q & 32'h5);
      report_test("uart loopback", fb, cb);
   endtask

   task automatic display_test();
      word_t       q;
      int          lat;
      int          fb;
      int          cb;
      int          d;
      logic [3:0]  seen;
      logic [15:0] shown;
      fb = fail_count;
      cb = pass_count + fail_count;
      seen = '0;
      shown = 16'hb6e1;
      // Source is read data at full brightness
      bus_xfer(1'b0, 1'b0, 1'b1, 20'h2, 32'h01, q, lat);
      bus_xfer(1'b1, 1'b0, 1'b1, 20'h2, '0, q, lat);
      check_value("disp cfg", 32'h01, q);
      bus_xfer(1'b0, 1'b1, 1'b0, 20'h00200, {16'h7777, shown}, q, lat);
      bus_xfer(1'b1, 1'b1, 1'b0, 20'h00200, '0, q, lat);
      check_value("rdata @00200", {16'h7777, shown}, q);
      repeat (4) @(negedge cpu_clk);
      for (int c = 0; c < 96; c++) begin
         @(negedge cpu_clk);
         case (an)
            4'b1110: d = 0;
            4'b1101: d = 1;
            4'b1011: d = 2;
            4'b0111: d = 3;
            default: d = -1;
         endcase
         if (d >= 0) begin
            check_value($sformatf("seg digit %0d", d), seg_pattern(shown[d*4 +: 4]), seg);
            seen[d] = 1'b1;
         end
      end
      expect_true(seen == 4'hf, "scanner did not enable every digit");
      report_test("display scan", fb, cb);
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------

   initial begin
      rst   <= 1'b1;
      req   <= 1'b0;
      rnw   <= 1'b1;
      vda   <= 1'b0;
      vio   <= 1'b0;
      addr  <= '0;
      wdata <= '0;
      lfsr_state = 32'h73c2_dd34;
      load_stimulus(loaded);
      cycle_limit = 3 * ((op_q.size() + 2 * LFSR_WORDS + EXTRA_XFERS) * 10
                         + UART_FRAMES * 10 * `OPC_CLKS_PER_BIT + 200);
      repeat (4) @(posedge cpu_clk);
      reset_test();
      @(posedge cpu_clk);
      rst <= 1'b0;
      if (loaded) begin
         file_test();
         lfsr_test();
         uart_test();
         display_test();
      end
      fail_count += u_opc_system.u_bus_bridge.u_opc_system_assertions.failures;
      $display("Summary: %0d checks passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* verification/opc_system_stimulus.txt */
# op space addr data expected
# op W or R, space M memory, I I/O, N none, then address, write data, read data in hex
W M 00000 1234abcd 00000000
W M 00001 deadbeef 00000000
W M 00002 0badf00d 00000000
W M 00003 55aa55aa 00000000
W M 003ff a5a5a5a5 00000000
R M 00000 00000000 1234abcd
R M 00001 00000000 deadbeef
R M 003ff 00000000 a5a5a5a5
W M 00001 cafe0001 00000000
R M 00001 00000000 cafe0001
W I 00003 ffffffff 00000000
R M 00003 00000000 55aa55aa
R I 00003 00000000 00000000
R N 00002 00000000 00000000
W I 00002 000000f1 00000000
R I 00002 00000000 000000f1
R M 00002 00000000 0badf00d
W I 00002 00000000 00000000
R I 00002 00000000 00000000

/* src.f */
+incdir+verilog
verilog/opc_sys_pkg.sv
verilog/word_ram.sv
verilog/uart.sv
verilog/display_regs.sv
verilog/sevenseg_scan.sv
verilog/bus_bridge.sv
verilog/opc_system.sv
verification/opc_system_assertions.sv
verification/tb_opc_system.sv

/* Bender.yml */
package:
  name: opc_system

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/opc_sys_pkg.sv
      - verilog/word_ram.sv
      - verilog/uart.sv
      - verilog/display_regs.sv
      - verilog/sevenseg_scan.sv
      - verilog/bus_bridge.sv
      - verilog/opc_system.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/opc_system_assertions.sv
      - verification/tb_opc_system.sv
